// ==== Makefile ====
# Verilator build and run of the thread engine testbench

TOP := tb_engine

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -Wno-fatal -f engine.f --top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

// ==== engine.f ====
+incdir+rtl
+incdir+tests
rtl/engine_pkg.sv
rtl/pc_fifo.sv
rtl/thread_queues.sv
rtl/slot_arbiter.sv
rtl/regex_cpu.sv
rtl/engine.sv
tests/tb_engine.sv

// ==== rtl/engine.sv ====
// thread engine top level
// slot queues, rotating arbiter and instruction cpu
// latency counter and status outputs
`timescale 1ns/1ps
`include "engine_settings.svh"

module engine (
    input  logic                              clk,
    input  logic                              rst,
    output logic                              accepts,
    output logic                              running,
    output logic                              full,
    output logic [`ENGINE_WINDOW-1:0]         elaborating_chars,
    input  logic [`ENGINE_WINDOW-1:0]         cur_window_end_of_s,
    input  logic [`ENGINE_WINDOW-1:0]         cur_window_enable,
    input  engine_pkg::char_t                 cur_window [`ENGINE_WINDOW-1:0],
    input  logic                              new_char,

    input  logic                              memory_ready,
    output logic [`ENGINE_MEM_ADDR_WIDTH-1:0] memory_addr,
    input  logic [`ENGINE_MEM_WIDTH-1:0]      memory_data,
    output logic                              memory_valid,

    input  logic                              input_pc_valid,
    input  engine_pkg::thread_t               input_pc_and_cc_id,
    output logic                              input_pc_ready,
    output logic [`ENGINE_LATENCY_WIDTH-1:0]  input_pc_latency,

    output logic                              output_pc_valid,
    output engine_pkg::thread_t               output_pc_and_cc_id,
    input  logic                              output_pc_ready
);
    // queues to arbiter
    logic [`ENGINE_WINDOW-1:0] head_valid;
    engine_pkg::thread_t       head [`ENGINE_WINDOW-1:0];
    logic [`ENGINE_WINDOW-1:0] q_pop;
    logic [`ENGINE_WINDOW-1:0] q_nonempty;

    // arbiter to cpu
    logic                      cpu_in_valid;
    engine_pkg::thread_t       cpu_in_thread;
    logic                      cpu_in_ready;
    logic                      cpu_busy;
    logic [`ENGINE_WINDOW-1:0] cpu_busy_slot;

    logic                      in_xfer;
    logic                      arb_xfer;

    ////////////////////
    // datapath
    ////////////////////
    thread_queues u_queues (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (input_pc_valid),
        .in_thread  (input_pc_and_cc_id),
        .in_ready   (input_pc_ready),
        .enable     (cur_window_enable),
        .pop        (q_pop),
        .head_valid (head_valid),
        .head       (head),
        .nonempty   (q_nonempty),
        .full       (full)
    );

    // priority rotates with every new character
    slot_arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .req        (head_valid),
        .cand       (head),
        .grant      (q_pop),
        .shift      (new_char),
        .out_valid  (cpu_in_valid),
        .out_thread (cpu_in_thread),
        .out_ready  (cpu_in_ready)
    );

    regex_cpu u_cpu (
        .clk          (clk),
        .rst          (rst),
        .cur_window   (cur_window),
        .end_of_s     (cur_window_end_of_s),
        .in_valid     (cpu_in_valid),
        .in_thread    (cpu_in_thread),
        .in_ready     (cpu_in_ready),
        .memory_valid (memory_valid),
        .memory_addr  (memory_addr),
        .memory_ready (memory_ready),
        .memory_data  (memory_data),
        .out_valid    (output_pc_valid),
        .out_thread   (output_pc_and_cc_id),
        .out_ready    (output_pc_ready),
        .accepts      (accepts),
        .busy         (cpu_busy),
        .busy_slot    (cpu_busy_slot)
    );

    ////////////////////
    // status
    ////////////////////
    assign in_xfer  = input_pc_valid && input_pc_ready;
    assign arb_xfer = cpu_in_valid && cpu_in_ready;

    // rough wait seen by a new thread, queued threads plus one
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            input_pc_latency <= `ENGINE_LATENCY_WIDTH'(1);
        end
        else
        begin
            case ({in_xfer, arb_xfer})
                2'b10:   input_pc_latency <= input_pc_latency + 1'b1;
                2'b01:   input_pc_latency <= input_pc_latency - 1'b1;
                default: input_pc_latency <= input_pc_latency;
            endcase
        end
    end

    assign running           = (|head_valid) || cpu_busy;
    assign elaborating_chars = q_nonempty | cpu_busy_slot;

endmodule

// ==== rtl/engine_pkg.sv ====
// shared types of the thread engine
// program counter, slot id, thread word, character and instruction
`include "engine_settings.svh"

package engine_pkg;

    typedef logic [`ENGINE_PC_WIDTH-1:0]   pc_t;
    typedef logic [`ENGINE_CC_ID_BITS-1:0] cc_id_t;
    typedef logic [`ENGINE_CHAR_WIDTH-1:0] char_t;

    // thread word, pc on top and slot id below
    typedef struct packed {
        pc_t    pc;
        cc_id_t cc_id;
    } thread_t;

    ////////////////////
    // instruction views
    ////////////////////

    // match view carries the character to compare
    typedef struct packed {
        logic [1:0] op;
        logic [5:0] unused;
        char_t      ch;
    } instr_match_t;

    // jump view carries the target pc
    typedef struct packed {
        logic [1:0] op;
        logic [5:0] unused;
        pc_t        target;
    } instr_jump_t;

    // one 16-bit word, decoded either way by the cpu
    typedef union packed {
        instr_match_t match_view;
        instr_jump_t  jump_view;
    } instr_t;

endpackage

// ==== rtl/engine_settings.svh ====
// engine widths, window size and queue depth
// instruction opcode encodings
`ifndef ENGINE_SETTINGS_SVH
`define ENGINE_SETTINGS_SVH

// instruction address, counted in 16-bit units
`define ENGINE_PC_WIDTH          8
// slot id width, window holds 2**bits characters
`define ENGINE_CC_ID_BITS        2
`define ENGINE_WINDOW            4
`define ENGINE_CHAR_WIDTH        8

// instruction and external memory geometry
`define ENGINE_INSTR_WIDTH       16
`define ENGINE_MEM_WIDTH         32
`define ENGINE_MEM_ADDR_WIDTH    7

// per-slot thread queue
`define ENGINE_FIFO_DEPTH        8
`define ENGINE_FIFO_COUNT_WIDTH  4
`define ENGINE_LATENCY_WIDTH     8

// opcodes in the top two instruction bits, 3 kills the thread
`define ENGINE_OP_MATCH          2'd0
`define ENGINE_OP_JUMP           2'd1
`define ENGINE_OP_ACCEPT         2'd2

`endif

// ==== rtl/pc_fifo.sv ====
// first-word-fall-through thread queue
// circular buffer with full, empty and fill count
`timescale 1ns/1ps
`include "engine_settings.svh"

module pc_fifo (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                push,
    input  engine_pkg::thread_t                 din,
    input  logic                                pop,
    output engine_pkg::thread_t                 dout,
    output logic                                full,
    output logic                                empty,
    output logic [`ENGINE_FIFO_COUNT_WIDTH-1:0] count
);
    localparam int PTR_W = $clog2(`ENGINE_FIFO_DEPTH);

    // storage, payload only
    engine_pkg::thread_t mem [`ENGINE_FIFO_DEPTH-1:0];
    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic                do_push;
    logic                do_pop;

    // overflow and underflow requests are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == `ENGINE_FIFO_COUNT_WIDTH'(`ENGINE_FIFO_DEPTH));
    assign empty = (count == '0);
    // head word always on the output
    assign dout  = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= din;
        end
    end

    // pointers wrap on their own, depth is a power of two
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== rtl/regex_cpu.sv ====
// single-thread instruction processor
// fetch from 32-bit memory, pick 16-bit half, run MATCH, JUMP or ACCEPT
`timescale 1ns/1ps
`include "engine_settings.svh"

module regex_cpu (
    input  logic                              clk,
    input  logic                              rst,
    input  engine_pkg::char_t                 cur_window [`ENGINE_WINDOW-1:0],
    input  logic [`ENGINE_WINDOW-1:0]         end_of_s,
    input  logic                              in_valid,
    input  engine_pkg::thread_t               in_thread,
    output logic                              in_ready,
    output logic                              memory_valid,
    output logic [`ENGINE_MEM_ADDR_WIDTH-1:0] memory_addr,
    input  logic                              memory_ready,
    input  logic [`ENGINE_MEM_WIDTH-1:0]      memory_data,
    output logic                              out_valid,
    output engine_pkg::thread_t               out_thread,
    input  logic                              out_ready,
    output logic                              accepts,
    output logic                              busy,
    output logic [`ENGINE_WINDOW-1:0]         busy_slot
);
    typedef enum logic [1:0] {
        S_IDLE,
        S_FETCH,
        S_EXEC,
        S_EMIT
    } state_t;

    state_t              state;
    // thread in flight and its result
    engine_pkg::thread_t cur_thread;
    engine_pkg::thread_t out_q;
    // which 16-bit half of the memory word holds the instruction
    logic                half_sel;

    // decode signals, valid in S_EXEC only
    engine_pkg::instr_t  instr;
    logic [1:0]          op;
    engine_pkg::char_t   slot_char;
    logic                hit;
    engine_pkg::thread_t match_next;
    engine_pkg::thread_t jump_next;

    ////////////////////
    // decode
    ////////////////////
    always_comb
    begin
        // memory word arrives the cycle after the transfer
        instr     = memory_data[half_sel*`ENGINE_INSTR_WIDTH +: `ENGINE_INSTR_WIDTH];
        op        = instr.match_view.op;
        slot_char = cur_window[cur_thread.cc_id];
        hit       = (instr.match_view.ch == slot_char);

        // match moves on to the next character slot
        match_next.pc    = cur_thread.pc + 1'b1;
        match_next.cc_id = cur_thread.cc_id + 1'b1;

        // jump stays on the same slot
        jump_next.pc     = instr.jump_view.target;
        jump_next.cc_id  = cur_thread.cc_id;
    end

    ////////////////////
    // control FSM
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= S_IDLE;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (in_valid)
                    begin
                        state <= S_FETCH;
                    end
                end
                S_FETCH:
                begin
                    if (memory_ready)
                    begin
                        state <= S_EXEC;
                    end
                end
                S_EXEC:
                begin
                    case (op)
                        `ENGINE_OP_MATCH: state <= hit ? S_EMIT : S_IDLE;
                        `ENGINE_OP_JUMP:  state <= S_EMIT;
                        // accept and kill both end the thread here
                        default:          state <= S_IDLE;
                    endcase
                end
                default:
                begin
                    // hold the result until the consumer takes it
                    if (out_ready)
                    begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    // thread, half select and result registers
    always_ff @(posedge clk)
    begin
        if (state == S_IDLE && in_valid)
        begin
            cur_thread <= in_thread;
        end
        if (state == S_FETCH && memory_ready)
        begin
            half_sel <= cur_thread.pc[0];
        end
        if (state == S_EXEC)
        begin
            out_q <= (op == `ENGINE_OP_JUMP) ? jump_next : match_next;
        end
    end

    ////////////////////
    // outputs
    ////////////////////
    assign in_ready     = (state == S_IDLE);
    assign memory_valid = (state == S_FETCH);
    // word address, pc counts 16-bit halves
    assign memory_addr  = cur_thread.pc[`ENGINE_PC_WIDTH-1:1];
    assign out_valid    = (state == S_EMIT);
    assign out_thread   = out_q;

    // one-cycle pulse when the slot is at end of string
    assign accepts = (state == S_EXEC) && (op == `ENGINE_OP_ACCEPT)
                     && end_of_s[cur_thread.cc_id];

    assign busy      = (state != S_IDLE);
    assign busy_slot = busy ? (`ENGINE_WINDOW'(1) << cur_thread.cc_id) : '0;

endmodule

// ==== rtl/slot_arbiter.sv ====
// rotating-priority pick among slot queue heads
// lowest-priority pointer steps once per new character
`timescale 1ns/1ps
`include "engine_settings.svh"

module slot_arbiter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`ENGINE_WINDOW-1:0] req,
    input  engine_pkg::thread_t       cand [`ENGINE_WINDOW-1:0],
    output logic [`ENGINE_WINDOW-1:0] grant,
    input  logic                      shift,
    output logic                      out_valid,
    output engine_pkg::thread_t       out_thread,
    input  logic                      out_ready
);
    // slot with the lowest priority
    engine_pkg::cc_id_t low_ptr;
    // winning slot and loop index
    engine_pkg::cc_id_t sel;
    engine_pkg::cc_id_t idx;
    logic               found;

    ////////////////////
    // priority pointer
    ////////////////////

    // last slot is lowest out of reset, so slot 0 wins first
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            low_ptr <= engine_pkg::cc_id_t'(`ENGINE_WINDOW - 1);
        end
        else if (shift)
        begin
            low_ptr <= low_ptr + 1'b1;
        end
    end

    ////////////////////
    // selection
    ////////////////////

    // scan from the slot after the pointer, wrapping round
    always_comb
    begin
        sel   = low_ptr;
        idx   = low_ptr;
        found = 1'b0;
        for (int k = 1; k <= `ENGINE_WINDOW; k++)
        begin
            idx = engine_pkg::cc_id_t'(low_ptr + k);
            if (!found && req[idx])
            begin
                sel   = idx;
                found = 1'b1;
            end
        end
    end

    assign out_valid  = found;
    assign out_thread = cand[sel];

    // pop the winner only when the cpu takes it
    assign grant = (out_valid && out_ready) ? (`ENGINE_WINDOW'(1) << sel) : '0;

endmodule

// ==== rtl/thread_queues.sv ====
// one thread queue per window slot
// input demux by slot id, enable masking, occupancy flags
`timescale 1ns/1ps
`include "engine_settings.svh"

module thread_queues (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  engine_pkg::thread_t       in_thread,
    output logic                      in_ready,
    input  logic [`ENGINE_WINDOW-1:0] enable,
    input  logic [`ENGINE_WINDOW-1:0] pop,
    output logic [`ENGINE_WINDOW-1:0] head_valid,
    output engine_pkg::thread_t       head [`ENGINE_WINDOW-1:0],
    output logic [`ENGINE_WINDOW-1:0] nonempty,
    output logic                      full
);
    logic [`ENGINE_WINDOW-1:0] q_push;
    logic [`ENGINE_WINDOW-1:0] q_full;
    logic [`ENGINE_WINDOW-1:0] q_empty;

    // accept only while every queue has room
    assign in_ready = ~|q_full;
    // engine counts as full once a single queue is
    assign full     = |q_full;

    // thread goes to every queue, push only on its own slot
    always_comb
    begin
        for (int i = 0; i < `ENGINE_WINDOW; i++)
        begin
            q_push[i] = in_valid && in_ready && (in_thread.cc_id == i);
        end
    end

    ////////////////////
    // slot queues
    ////////////////////
    for (genvar g = 0; g < `ENGINE_WINDOW; g++)
    begin : g_slot
        pc_fifo u_fifo (
            .clk   (clk),
            .rst   (rst),
            .push  (q_push[g]),
            .din   (in_thread),
            .pop   (pop[g]),
            .dout  (head[g]),
            .full  (q_full[g]),
            .empty (q_empty[g]),
            .count ()
        );

        // disabled slots hide their head from the arbiter
        assign nonempty[g]   = !q_empty[g];
        assign head_valid[g] = !q_empty[g] && enable[g];
    end

endmodule

// ==== tests/tb_engine_model.svh ====
// program image, random number generator and reference model
// order-free scoreboard of predicted output threads and accept count
`ifndef TB_ENGINE_MODEL_SVH
`define TB_ENGINE_MODEL_SVH

// program memory, two instructions per word
logic [`ENGINE_MEM_WIDTH-1:0] image [0:(1<<`ENGINE_MEM_ADDR_WIDTH)-1];
int unsigned                  rand_state = 87104;
// predicted output threads, any order
engine_pkg::thread_t          predicted [$];
int                           expected_accepts;

// linear congruential generator, upper bits are the better ones
function automatic int unsigned next_rand();
    rand_state = rand_state * 32'd1103515245 + 32'd12345;
    return rand_state >> 16;
endfunction

// mix of 40% match, 30% jump, 20% accept, 10% kill
function automatic engine_pkg::instr_t random_instr();
    engine_pkg::instr_t ins;
    int unsigned        kind;
    kind = next_rand() % 10;
    ins  = '0;
    if (kind < 4)
    begin
        ins.match_view.op = `ENGINE_OP_MATCH;
        // mostly characters present in the window so that matches hit
        if (next_rand() % 4 == 0)
        begin
            ins.match_view.ch = engine_pkg::char_t'(next_rand());
        end
        else
        begin
            ins.match_view.ch = cur_window[next_rand() % `ENGINE_WINDOW];
        end
    end
    else if (kind < 7)
    begin
        ins.jump_view.op     = `ENGINE_OP_JUMP;
        ins.jump_view.target = engine_pkg::pc_t'(next_rand());
    end
    else if (kind < 9)
    begin
        ins.match_view.op = `ENGINE_OP_ACCEPT;
    end
    else
    begin
        ins.match_view.op = 2'd3;
    end
    return ins;
endfunction

task automatic fill_image();
    foreach (image[w])
    begin
        image[w] = {random_instr(), random_instr()};
    end
endtask

// expected effect of one thread entering the cpu
function automatic void predict(engine_pkg::thread_t t);
    logic [`ENGINE_MEM_WIDTH-1:0] word;
    engine_pkg::instr_t           ins;
    engine_pkg::thread_t          nxt;
    word = image[t.pc[`ENGINE_PC_WIDTH-1:1]];
    // odd pc sits in the upper half of the word
    ins  = t.pc[0] ? word[31:16] : word[15:0];
    case (ins.match_view.op)
        `ENGINE_OP_MATCH:
        begin
            if (ins.match_view.ch == cur_window[t.cc_id])
            begin
                nxt.pc    = t.pc + 1'b1;
                nxt.cc_id = engine_pkg::cc_id_t'((int'(t.cc_id) + 1) % `ENGINE_WINDOW);
                predicted.push_back(nxt);
            end
        end
        `ENGINE_OP_JUMP:
        begin
            nxt.pc    = ins.jump_view.target;
            nxt.cc_id = t.cc_id;
            predicted.push_back(nxt);
        end
        `ENGINE_OP_ACCEPT:
        begin
            if (cur_window_end_of_s[t.cc_id])
            begin
                expected_accepts++;
            end
        end
        // opcode 3, thread dies quietly
        default:
        begin
        end
    endcase
endfunction

// take one output thread off the scoreboard
task automatic retire_output(engine_pkg::thread_t got);
    int idx;
    idx = -1;
    foreach (predicted[i])
    begin
        if (idx < 0 && predicted[i] == got)
        begin
            idx = i;
        end
    end
    if (idx >= 0)
    begin
        predicted.delete(idx);
    end
    else if (predicted.size() == 0)
    begin
        report_failure($sformatf("output thread %h appeared with nothing predicted", got));
    end
    else
    begin
        // no entry fits, show the oldest one
        check_thread(got, predicted[0], "output thread not in scoreboard");
    end
endtask

`endif

// ==== tests/tb_engine.sv ====
// testbench for the thread engine
// clock, reset, random traffic, memory responder, checks and timeout
`timescale 1ns/1ps
`include "engine_settings.svh"

module tb_engine;

    localparam int N_RANDOM   = 40;
    localparam int N_DISABLED = 6;
    localparam int N_BACKPRES = 20;
    // 40 cycles per thread plus slack
    localparam int MAX_CYCLES = 40 * (N_RANDOM + N_DISABLED + N_BACKPRES) + 200;

    logic                              clk;
    logic                              rst;
    logic                              accepts;
    logic                              running;
    logic                              full;
    logic [`ENGINE_WINDOW-1:0]         elaborating_chars;
    logic [`ENGINE_WINDOW-1:0]         cur_window_end_of_s;
    logic [`ENGINE_WINDOW-1:0]         cur_window_enable;
    engine_pkg::char_t                 cur_window [`ENGINE_WINDOW-1:0];
    logic                              new_char;
    logic                              memory_ready;
    logic [`ENGINE_MEM_ADDR_WIDTH-1:0] memory_addr;
    logic [`ENGINE_MEM_WIDTH-1:0]      memory_data;
    logic                              memory_valid;
    logic                              input_pc_valid;
    engine_pkg::thread_t               input_pc_and_cc_id;
    logic                              input_pc_ready;
    logic [`ENGINE_LATENCY_WIDTH-1:0]  input_pc_latency;
    logic                              output_pc_valid;
    engine_pkg::thread_t               output_pc_and_cc_id;
    logic                              output_pc_ready;

    // traffic control
    engine_pkg::thread_t               to_send [$];
    logic                              stall_output;
    logic                              input_gaps;
    logic                              in_taken;
    logic [`ENGINE_WINDOW-1:0]         enable_next;
    // memory request taken at the coming edge
    logic                              mem_pending;
    logic [`ENGINE_MEM_ADDR_WIDTH-1:0] mem_addr_q;
    int                                cycles;
    int                                accept_pulses;

    engine engine_i (
        .clk                 (clk),
        .rst                 (rst),
        .accepts             (accepts),
        .running             (running),
        .full                (full),
        .elaborating_chars   (elaborating_chars),
        .cur_window_end_of_s (cur_window_end_of_s),
        .cur_window_enable   (cur_window_enable),
        .cur_window          (cur_window),
        .new_char            (new_char),
        .memory_ready        (memory_ready),
        .memory_addr         (memory_addr),
        .memory_data         (memory_data),
        .memory_valid        (memory_valid),
        .input_pc_valid      (input_pc_valid),
        .input_pc_and_cc_id  (input_pc_and_cc_id),
        .input_pc_ready      (input_pc_ready),
        .input_pc_latency    (input_pc_latency),
        .output_pc_valid     (output_pc_valid),
        .output_pc_and_cc_id (output_pc_and_cc_id),
        .output_pc_ready     (output_pc_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #4 clk = ~clk;
        end
    end

    ////////////////////
    // checks
    ////////////////////
    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_thread(engine_pkg::thread_t got, engine_pkg::thread_t exp, string what);
        if (got !== exp)
        begin
            report_failure($sformatf("Mismatch at %0t: %s, got pc %h cc %0d, expected pc %h cc %0d",
                                     $time, what, got.pc, got.cc_id, exp.pc, exp.cc_id));
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp)
        begin
            report_failure($sformatf("Mismatch at %0t: %s, got %b expected %b",
                                     $time, what, got, exp));
        end
    endtask

    task automatic check_count(logic [`ENGINE_LATENCY_WIDTH-1:0] got,
                               logic [`ENGINE_LATENCY_WIDTH-1:0] exp, string what);
        if (got !== exp)
        begin
            report_failure($sformatf("Mismatch at %0t: %s, got %0d expected %0d",
                                     $time, what, got, exp));
        end
    endtask

    `include "tb_engine_model.svh"

    ////////////////////
    // per-cycle driver and monitor
    ////////////////////

    // drive 1 ns after the edge, sample at the falling edge
    task automatic step();
        @(posedge clk);
        #1;
        // memory word lives for one cycle only
        memory_data     = mem_pending ? image[mem_addr_q] : '0;
        mem_pending     = 1'b0;
        memory_ready    = (next_rand() % 10) < 7;
        output_pc_ready = !stall_output && ((next_rand() % 4) != 0);
        new_char        = (next_rand() % 8) == 0;
        cur_window_enable = enable_next;
        if (in_taken)
        begin
            input_pc_valid = 1'b0;
            in_taken       = 1'b0;
        end
        if (!input_pc_valid && to_send.size() > 0 && (!input_gaps || next_rand() % 2 == 0))
        begin
            input_pc_and_cc_id = to_send.pop_front();
            input_pc_valid     = 1'b1;
        end
        @(negedge clk);
        // transfers below complete at the next rising edge
        if (input_pc_valid && input_pc_ready)
        begin
            predict(input_pc_and_cc_id);
            in_taken = 1'b1;
        end
        if (output_pc_valid && output_pc_ready)
        begin
            retire_output(output_pc_and_cc_id);
        end
        if (memory_valid && memory_ready)
        begin
            mem_pending = 1'b1;
            mem_addr_q  = memory_addr;
        end
        if (accepts)
        begin
            accept_pulses++;
        end
        cycles++;
        if (cycles > MAX_CYCLES)
        begin
            report_failure($sformatf("timeout, run still busy after %0d cycles", MAX_CYCLES));
        end
    endtask

    // slot below zero means a random slot
    task automatic queue_threads(int n, int slot);
        engine_pkg::thread_t t;
        for (int i = 0; i < n; i++)
        begin
            t.pc    = engine_pkg::pc_t'(next_rand());
            t.cc_id = (slot < 0) ? engine_pkg::cc_id_t'(next_rand()) : engine_pkg::cc_id_t'(slot);
            to_send.push_back(t);
        end
    endtask

    task automatic send_all();
        while (to_send.size() > 0 || input_pc_valid)
        begin
            step();
        end
    endtask

    // run until no slot holds or runs a thread, masked slots included
    task automatic drain();
        while (to_send.size() > 0 || input_pc_valid
               || (|elaborating_chars) || output_pc_valid)
        begin
            step();
        end
    endtask

    ////////////////////
    // test sequence
    ////////////////////
    initial
    begin
        rst                 = 1'b1;
        new_char            = 1'b0;
        memory_ready        = 1'b0;
        memory_data         = '0;
        input_pc_valid      = 1'b0;
        input_pc_and_cc_id  = '0;
        output_pc_ready     = 1'b0;
        cur_window_enable   = '1;
        stall_output        = 1'b0;
        input_gaps          = 1'b1;
        in_taken            = 1'b0;
        enable_next         = '1;
        mem_pending         = 1'b0;
        mem_addr_q          = '0;
        cycles              = 0;
        accept_pulses       = 0;
        expected_accepts    = 0;
        // window of lower case letters, at least slot 0 at end of string
        foreach (cur_window[i])
        begin
            cur_window[i] = engine_pkg::char_t'(8'h61 + next_rand() % 4);
        end
        cur_window_end_of_s = `ENGINE_WINDOW'(next_rand()) | `ENGINE_WINDOW'(1);
        fill_image();

        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        check_flag(input_pc_ready, 1'b1, "input_pc_ready after reset");
        check_count(input_pc_latency, 1, "input_pc_latency after reset");
        check_flag(running, 1'b0, "running after reset");
        check_flag(full, 1'b0, "full after reset");
        check_flag(accepts, 1'b0, "accepts after reset");
        check_flag(output_pc_valid, 1'b0, "output_pc_valid after reset");
        check_flag(|elaborating_chars, 1'b0, "elaborating_chars after reset");

        // random threads on every slot
        queue_threads(N_RANDOM, -1);
        drain();
        check_count(input_pc_latency, 1, "input_pc_latency after random traffic");

        // slot 3 masked, its threads must wait
        enable_next = 4'b0111;
        queue_threads(N_DISABLED, 3);
        send_all();
        repeat (20)
        begin
            step();
            check_flag(output_pc_valid, 1'b0, "output from a disabled slot");
            check_flag(running, 1'b0, "running with only a disabled slot queued");
        end
        check_flag(elaborating_chars[3], 1'b1, "elaborating_chars of the disabled slot");
        check_count(input_pc_latency, 1 + N_DISABLED, "input_pc_latency with slot 3 held");
        enable_next = '1;
        drain();

        // back-pressure on the output until a queue fills
        stall_output = 1'b1;
        input_gaps   = 1'b0;
        queue_threads(N_BACKPRES, 1);
        while (!full)
        begin
            step();
        end
        check_flag(input_pc_ready, 1'b0, "input_pc_ready with a full queue");
        stall_output = 1'b0;
        input_gaps   = 1'b1;
        drain();

        check_count(input_pc_latency, 1, "input_pc_latency after drain");
        check_flag(running, 1'b0, "running after drain");
        check_count(`ENGINE_LATENCY_WIDTH'(accept_pulses),
                    `ENGINE_LATENCY_WIDTH'(expected_accepts), "accept pulse count");
        if (predicted.size() != 0)
        begin
            report_failure($sformatf("%0d predicted output threads never came out",
                                     predicted.size()));
        end
        else
        begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule
